//--- common/mbox_cfg.svh
/*
 * mailbox configuration
 * word width, capacity, request address width and the register window base
 */

`ifndef MBOX_CFG_SVH
`define MBOX_CFG_SVH

// width of one mailbox data word in bits
`define MBOX_DATA_W 32

// capacity of the mailbox SRAM in kilobytes
`define MBOX_SIZE_KB 1

// number of words held by the SRAM, derived from the capacity
`define MBOX_DEPTH ((`MBOX_SIZE_KB * 1024 * 8) / `MBOX_DATA_W)

// width of a request byte address
`define MBOX_ADDR_W 16

// base of the register window, only bits 15 down to 10 take part in the decode
`define MBOX_CSR_BASE 16'h0000

`endif

//--- common/mbox_pkg.sv
/*
 * mailbox datapath package
 * word, address, pointer and user types plus the protocol FSM states
 */

`include "mbox_cfg.svh"

package mbox_pkg;

    // one mailbox data word
    typedef logic [`MBOX_DATA_W-1:0] data_t;

    // byte address as seen on the request port
    typedef logic [`MBOX_ADDR_W-1:0] addr_t;

    // word index into the mailbox SRAM
    typedef logic [$clog2(`MBOX_DEPTH)-1:0] ptr_t;

    // user attribute that comes with every SoC request
    typedef logic [7:0] user_t;

    // protocol states, the lock owner walks through them in this order
    // the execute state is named after the side that has to consume the data
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5
    } mbox_fsm_state_e;

endpackage

//--- common/mbox_reg_pkg.sv
/*
 * mailbox register map
 * byte offsets of the registers inside the register window
 */

package mbox_reg_pkg;

    // the low six address bits select a register
    typedef logic [5:0] reg_off_t;

    // reading the lock while it is free acquires it
    localparam reg_off_t LOCK_OFF    = 6'h00;
    localparam reg_off_t USER_OFF    = 6'h04;
    localparam reg_off_t CMD_OFF     = 6'h08;
    localparam reg_off_t DLEN_OFF    = 6'h0C;

    // datain has no storage, a write goes straight into the SRAM
    localparam reg_off_t DATAIN_OFF  = 6'h10;

    // every read of dataout advances the read pointer
    localparam reg_off_t DATAOUT_OFF = 6'h14;
    localparam reg_off_t EXECUTE_OFF = 6'h18;

endpackage

//--- compile.f
+incdir+common
common/mbox_pkg.sv
common/mbox_reg_pkg.sv
rtl/mbox_sram.sv
mbox/mbox_csr.sv
mbox/mbox.sv
rtl/mbox_top.sv
verif/mbox_checker.sv
verif/mbox_tb.sv

//--- mbox/mbox.sv
/*
 * mailbox core
 * runs the lock and transfer protocol, checks the requester against the lock owner,
 * steers the SRAM between the protocol pointers and the direct uc path
 */
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox (
    input  logic            clk,
    input  logic            rst_b,
    input  logic            req_dv,
    input  logic            dir_req_dv,
    input  logic            req_write,
    input  logic            req_soc,
    input  mbox_pkg::addr_t req_addr,
    input  mbox_pkg::data_t req_wdata,
    input  mbox_pkg::user_t req_user,
    output mbox_pkg::data_t rdata,
    output logic            req_hold,
    output logic            mbox_error,
    output logic            uc_mbox_data_avail,
    output logic            soc_mbox_data_avail,
    output logic            sram_cs,
    output logic            sram_we,
    output mbox_pkg::ptr_t  sram_addr,
    output mbox_pkg::data_t sram_wdata,
    input  mbox_pkg::data_t sram_rdata
);

    localparam int              PTR_W    = $bits(mbox_pkg::ptr_t);
    localparam mbox_pkg::addr_t CSR_BASE = `MBOX_CSR_BASE;

    mbox_pkg::mbox_fsm_state_e fsm_ps;
    mbox_pkg::mbox_fsm_state_e fsm_ns;
    logic                      reg_sel;
    mbox_reg_pkg::reg_off_t    reg_off;
    mbox_pkg::data_t           csr_rdata;
    logic                      lock_value;
    logic                      cmd_wr;
    logic                      dlen_wr;
    logic                      datain_wr;
    logic                      dataout_rd;
    logic                      execute_value;
    mbox_pkg::user_t           user_value;
    logic                      valid_user;
    logic                      dataout_we;
    mbox_pkg::data_t           dataout_next;
    logic                      soc_has_lock;
    logic                      arc_lock;
    logic                      arc_release;
    logic                      inc_wrptr;
    logic                      inc_rdptr;
    logic                      inc_rdptr_f;
    logic                      inc_rdptr_ff;
    logic                      rst_ptr;
    logic                      update_dataout;
    mbox_pkg::ptr_t            wrptr;
    mbox_pkg::ptr_t            rdptr;
    logic                      dir_req_q;
    logic                      dir_rd_f;

    // register window decode on the upper address bits
    assign reg_sel = req_dv & (req_addr[`MBOX_ADDR_W-1:10] == CSR_BASE[`MBOX_ADDR_W-1:10]);
    assign reg_off = req_addr[5:0];

    // a read of the free lock takes it, the requester side is remembered below
    assign arc_lock = (fsm_ps == mbox_pkg::MBOX_IDLE) & reg_sel & ~req_write &
                      (reg_off == mbox_reg_pkg::LOCK_OFF) & ~lock_value;
    // clearing execute hands the mailbox back
    assign arc_release = ((fsm_ps == mbox_pkg::MBOX_EXECUTE_UC) |
                          (fsm_ps == mbox_pkg::MBOX_EXECUTE_SOC)) & ~execute_value;

    always_comb begin
        fsm_ns    = fsm_ps;
        inc_wrptr = 1'b0;
        inc_rdptr = 1'b0;
        rst_ptr   = 1'b0;
        unique case (fsm_ps)
            mbox_pkg::MBOX_IDLE: begin
                if (arc_lock) fsm_ns = mbox_pkg::MBOX_RDY_FOR_CMD;
            end
            mbox_pkg::MBOX_RDY_FOR_CMD: begin
                if (cmd_wr & valid_user) fsm_ns = mbox_pkg::MBOX_RDY_FOR_DLEN;
            end
            mbox_pkg::MBOX_RDY_FOR_DLEN: begin
                if (dlen_wr & valid_user) fsm_ns = mbox_pkg::MBOX_RDY_FOR_DATA;
            end
            mbox_pkg::MBOX_RDY_FOR_DATA: begin
                // only the owner moves the pointers while data is loaded
                inc_wrptr = datain_wr & valid_user;
                inc_rdptr = dataout_rd & valid_user;
                // execute means the other side now owns the data
                if (execute_value) begin
                    fsm_ns = soc_has_lock ? mbox_pkg::MBOX_EXECUTE_UC
                                          : mbox_pkg::MBOX_EXECUTE_SOC;
                end
            end
            mbox_pkg::MBOX_EXECUTE_UC, mbox_pkg::MBOX_EXECUTE_SOC: begin
                // the receiving side reads dataout without owning the lock
                inc_rdptr = dataout_rd;
                if (arc_release) begin
                    fsm_ns  = mbox_pkg::MBOX_IDLE;
                    rst_ptr = 1'b1;
                end
            end
            default: fsm_ns = mbox_pkg::MBOX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            fsm_ps       <= mbox_pkg::MBOX_IDLE;
            soc_has_lock <= 1'b0;
            wrptr        <= '0;
            rdptr        <= '0;
            inc_rdptr_f  <= 1'b0;
            inc_rdptr_ff <= 1'b0;
            dir_rd_f     <= 1'b0;
        end else begin
            fsm_ps <= fsm_ns;
            if (arc_lock) soc_has_lock <= req_soc;
            if (rst_ptr) wrptr <= '0;
            else if (inc_wrptr) wrptr <= wrptr + mbox_pkg::ptr_t'(1);
            if (rst_ptr) rdptr <= '0;
            else if (inc_rdptr) rdptr <= rdptr + mbox_pkg::ptr_t'(1);
            // SRAM read one cycle after the pointer moves, dataout load one cycle later
            inc_rdptr_f  <= inc_rdptr;
            inc_rdptr_ff <= inc_rdptr_f;
            // marks the held data phase of a direct read
            dir_rd_f <= dir_req_q & ~req_write;
        end
    end

    // uc requests pass when the uc owns the lock, SoC ones also need the stored user
    assign valid_user = lock_value & ((~soc_has_lock & ~req_soc) |
                        (soc_has_lock & req_soc & (req_user == user_value)));

    // data is flagged from the execute edge to the edge that clears execute
    assign uc_mbox_data_avail  = execute_value & soc_has_lock &
                                 ((fsm_ps == mbox_pkg::MBOX_RDY_FOR_DATA) |
                                  (fsm_ps == mbox_pkg::MBOX_EXECUTE_UC));
    assign soc_mbox_data_avail = execute_value & ~soc_has_lock &
                                 ((fsm_ps == mbox_pkg::MBOX_RDY_FOR_DATA) |
                                  (fsm_ps == mbox_pkg::MBOX_EXECUTE_SOC));

    // direct access is uc only, the held second cycle of a read starts nothing new
    assign dir_req_q = dir_req_dv & ~req_soc & ~dir_rd_f;
    assign req_hold  = dir_req_q & ~req_write;
    assign rdata     = dir_rd_f ? sram_rdata : csr_rdata;

    // direct requests use the word part of the byte address
    assign sram_we    = (dir_req_q & req_write) | inc_wrptr;
    assign sram_cs    = dir_req_q | sram_we | inc_rdptr_f;
    assign sram_addr  = dir_req_q ? req_addr[PTR_W+1:2] : (sram_we ? wrptr : rdptr);
    assign sram_wdata = req_wdata;

    // a datain write into the slot under the read pointer refreshes dataout at once
    assign update_dataout = inc_wrptr & (wrptr == rdptr);
    assign dataout_we     = update_dataout | inc_rdptr_ff;
    assign dataout_next   = update_dataout ? req_wdata : sram_rdata;

    mbox_csr u_csr (
        .clk           (clk),
        .rst_b         (rst_b),
        .reg_sel       (reg_sel),
        .reg_write     (req_write),
        .reg_off       (reg_off),
        .reg_wdata     (req_wdata),
        .reg_rdata     (csr_rdata),
        .reg_err       (mbox_error),
        .lock_set      (arc_lock),
        .lock_clr      (arc_release),
        .valid_user    (valid_user),
        .dataout_we    (dataout_we),
        .dataout_next  (dataout_next),
        .user_next     (req_user),
        .lock_value    (lock_value),
        .cmd_wr        (cmd_wr),
        .dlen_wr       (dlen_wr),
        .datain_wr     (datain_wr),
        .dataout_rd    (dataout_rd),
        .execute_value (execute_value),
        .user_value    (user_value)
    );

endmodule

//--- mbox/mbox_csr.sv
/*
 * mailbox register block
 * holds lock, user, command, length, dataout and execute, decodes offsets,
 * produces the access pulses for the protocol FSM and flags undefined offsets
 */
`timescale 1ns/1ps

module mbox_csr (
    input  logic                   clk,
    input  logic                   rst_b,
    input  logic                   reg_sel,
    input  logic                   reg_write,
    input  mbox_reg_pkg::reg_off_t reg_off,
    input  mbox_pkg::data_t        reg_wdata,
    output mbox_pkg::data_t        reg_rdata,
    output logic                   reg_err,
    input  logic                   lock_set,
    input  logic                   lock_clr,
    input  logic                   valid_user,
    input  logic                   dataout_we,
    input  mbox_pkg::data_t        dataout_next,
    input  mbox_pkg::user_t        user_next,
    output logic                   lock_value,
    output logic                   cmd_wr,
    output logic                   dlen_wr,
    output logic                   datain_wr,
    output logic                   dataout_rd,
    output logic                   execute_value,
    output mbox_pkg::user_t        user_value
);

    logic            rd_acc;
    logic            wr_acc;
    logic            hit_lock;
    logic            hit_user;
    logic            hit_cmd;
    logic            hit_dlen;
    logic            hit_datain;
    logic            hit_dataout;
    logic            hit_execute;
    logic            execute_wr;
    mbox_pkg::data_t cmd_q;
    mbox_pkg::data_t dlen_q;
    mbox_pkg::data_t dataout_q;

    assign rd_acc = reg_sel & ~reg_write;
    assign wr_acc = reg_sel & reg_write;

    // one hit per defined register
    assign hit_lock    = (reg_off == mbox_reg_pkg::LOCK_OFF);
    assign hit_user    = (reg_off == mbox_reg_pkg::USER_OFF);
    assign hit_cmd     = (reg_off == mbox_reg_pkg::CMD_OFF);
    assign hit_dlen    = (reg_off == mbox_reg_pkg::DLEN_OFF);
    assign hit_datain  = (reg_off == mbox_reg_pkg::DATAIN_OFF);
    assign hit_dataout = (reg_off == mbox_reg_pkg::DATAOUT_OFF);
    assign hit_execute = (reg_off == mbox_reg_pkg::EXECUTE_OFF);

    // any access that matches none of the registers is an error, read or write
    assign reg_err = reg_sel & ~(hit_lock | hit_user | hit_cmd | hit_dlen |
                                 hit_datain | hit_dataout | hit_execute);

    // raw access pulses, the FSM decides whether the requester may use them
    assign cmd_wr     = wr_acc & hit_cmd;
    assign dlen_wr    = wr_acc & hit_dlen;
    assign datain_wr  = wr_acc & hit_datain;
    assign execute_wr = wr_acc & hit_execute;
    assign dataout_rd = rd_acc & hit_dataout;

    // read data comes straight from the registers in the request cycle
    // datain reads back as zero since nothing is stored for it
    always_comb begin
        reg_rdata = '0;
        if (rd_acc) begin
            if (hit_lock)    reg_rdata = mbox_pkg::data_t'(lock_value);
            if (hit_user)    reg_rdata = mbox_pkg::data_t'(user_value);
            if (hit_cmd)     reg_rdata = cmd_q;
            if (hit_dlen)    reg_rdata = dlen_q;
            if (hit_dataout) reg_rdata = dataout_q;
            if (hit_execute) reg_rdata = mbox_pkg::data_t'(execute_value);
        end
    end

    // lock clear wins over set, both come from the FSM and never overlap in practice
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_value    <= 1'b0;
            user_value    <= '0;
            cmd_q         <= '0;
            dlen_q        <= '0;
            execute_value <= 1'b0;
        end else begin
            if (lock_clr) lock_value <= 1'b0;
            else if (lock_set) lock_value <= 1'b1;
            // the user of the requester is captured when it takes the lock
            if (lock_set) user_value <= user_next;
            if (cmd_wr & valid_user) cmd_q <= reg_wdata;
            if (dlen_wr & valid_user) dlen_q <= reg_wdata;
            if (execute_wr & valid_user) execute_value <= reg_wdata[0];
        end
    end

    // dataout is only ever loaded by hardware, from the SRAM or from a datain write
    always_ff @(posedge clk) begin
        if (dataout_we) dataout_q <= dataout_next;
    end

endmodule

//--- rtl/mbox_sram.sv
/*
 * mailbox SRAM
 * single port, synchronous write, read data registered one cycle after chip select
 */
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox_sram #(
    parameter int DEPTH = `MBOX_DEPTH
) (
    input  logic            clk,
    input  logic            cs,
    input  logic            we,
    input  mbox_pkg::ptr_t  addr,
    input  mbox_pkg::data_t wdata,
    output mbox_pkg::data_t rdata
);

    mbox_pkg::data_t mem [DEPTH];

    // rdata keeps its last value between reads, the direct path relies on that
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) mem[addr] <= wdata;
            else rdata <= mem[addr];
        end
    end

endmodule

//--- rtl/mbox_top.sv
/*
 * mailbox top level
 * joins the mailbox core with its SRAM
 */
`timescale 1ns/1ps

module mbox_top (
    input  logic            clk,
    input  logic            rst_b,
    input  logic            req_dv,
    input  logic            dir_req_dv,
    input  logic            req_write,
    input  logic            req_soc,
    input  mbox_pkg::addr_t req_addr,
    input  mbox_pkg::data_t req_wdata,
    input  mbox_pkg::user_t req_user,
    output mbox_pkg::data_t rdata,
    output logic            req_hold,
    output logic            mbox_error,
    output logic            uc_mbox_data_avail,
    output logic            soc_mbox_data_avail
);

    // core to SRAM
    logic            sram_cs;
    logic            sram_we;
    mbox_pkg::ptr_t  sram_addr;
    mbox_pkg::data_t sram_wdata;
    mbox_pkg::data_t sram_rdata;

    mbox u_mbox (
        .clk                 (clk),
        .rst_b               (rst_b),
        .req_dv              (req_dv),
        .dir_req_dv          (dir_req_dv),
        .req_write           (req_write),
        .req_soc             (req_soc),
        .req_addr            (req_addr),
        .req_wdata           (req_wdata),
        .req_user            (req_user),
        .rdata               (rdata),
        .req_hold            (req_hold),
        .mbox_error          (mbox_error),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail),
        .sram_cs             (sram_cs),
        .sram_we             (sram_we),
        .sram_addr           (sram_addr),
        .sram_wdata          (sram_wdata),
        .sram_rdata          (sram_rdata)
    );

    mbox_sram u_sram (
        .clk   (clk),
        .cs    (sram_cs),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the mailbox testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mbox_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmbox_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^NO ERRORS$"; then
    exit 0
fi
exit 1

//--- verif/mbox_checker.sv
/*
 * mailbox response checker
 * samples the DUT outputs on every rising edge, compares the ones the testbench
 * selects with the expected value and reports each test when it ends
 */
`timescale 1ns/1ps

module mbox_checker (
    input  logic            clk,
    input  mbox_pkg::data_t rdata,
    input  logic            req_hold,
    input  logic            mbox_error,
    input  logic            uc_mbox_data_avail,
    input  logic            soc_mbox_data_avail,
    input  logic            chk_rdata,
    input  logic            chk_hold,
    input  logic            chk_err,
    input  logic            chk_levels,
    input  mbox_pkg::data_t exp_value,
    input  logic            test_end,
    input  int              test_num,
    output int              checks,
    output int              errors
);

    int n_checks = 0;
    int n_errors = 0;
    int test_errors = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    // one comparison, a mismatch is reported right away
    task automatic compare(input string name, input mbox_pkg::data_t got,
                           input mbox_pkg::data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errors++;
            $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // outputs are sampled before the edge updates any register, so they belong
    // to the request cycle that ends here
    always @(posedge clk) begin
        if (chk_rdata) begin
            compare("rdata", rdata, exp_value);
        end
        if (chk_hold) begin
            compare("req_hold", mbox_pkg::data_t'(req_hold), mbox_pkg::data_t'(exp_value[0]));
        end
        if (chk_err) begin
            compare("mbox_error", mbox_pkg::data_t'(mbox_error),
                    mbox_pkg::data_t'(exp_value[0]));
        end
        // level check packs {req_hold, mbox_error, uc avail, soc avail} into bits 3 to 0
        if (chk_levels) begin
            compare("req_hold", mbox_pkg::data_t'(req_hold), mbox_pkg::data_t'(exp_value[3]));
            compare("mbox_error", mbox_pkg::data_t'(mbox_error),
                    mbox_pkg::data_t'(exp_value[2]));
            compare("uc_mbox_data_avail", mbox_pkg::data_t'(uc_mbox_data_avail),
                    mbox_pkg::data_t'(exp_value[1]));
            compare("soc_mbox_data_avail", mbox_pkg::data_t'(soc_mbox_data_avail),
                    mbox_pkg::data_t'(exp_value[0]));
        end
        if (test_end) begin
            $display("test %0d %s, %0d errors", test_num,
                     (test_errors == 0) ? "passed" : "failed", test_errors);
            test_errors = 0;
        end
    end

endmodule

//--- verif/mbox_tb.sv
/*
 * mailbox testbench
 * builds a table of requests with expected responses and applies it to the
 * mailbox on falling clock edges, the checker module does the comparing
 */
`timescale 1ns/1ps
`include "mbox_cfg.svh"

module mbox_tb;

    localparam int MAX_ROWS = 64;
    localparam int TIMEOUT  = 40;

    // row kinds of the stimulus table
    localparam int K_RD     = 0;
    localparam int K_WR     = 1;
    localparam int K_ERR    = 2;
    localparam int K_DWR    = 3;
    localparam int K_DRD    = 4;
    localparam int K_IDLE   = 5;
    localparam int K_LEVELS = 6;
    localparam int K_WAIT   = 7;
    localparam int K_END    = 8;

    logic            clk;
    logic            rst_b;
    logic            req_dv;
    logic            dir_req_dv;
    logic            req_write;
    logic            req_soc;
    mbox_pkg::addr_t req_addr;
    mbox_pkg::data_t req_wdata;
    mbox_pkg::user_t req_user;
    mbox_pkg::data_t rdata;
    logic            req_hold;
    logic            mbox_error;
    logic            uc_mbox_data_avail;
    logic            soc_mbox_data_avail;
    logic            chk_rdata;
    logic            chk_hold;
    logic            chk_err;
    logic            chk_levels;
    mbox_pkg::data_t exp_value;
    logic            test_end;
    int              test_num;
    int              checks;
    int              errors;
    logic            timed_out;

    // stimulus table, one entry per column
    int              row_kind [MAX_ROWS];
    mbox_pkg::addr_t row_addr [MAX_ROWS];
    logic            row_soc [MAX_ROWS];
    mbox_pkg::user_t row_user [MAX_ROWS];
    mbox_pkg::data_t row_wdata [MAX_ROWS];
    mbox_pkg::data_t row_exp [MAX_ROWS];
    int              num_rows;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    mbox_top dut0 (
        .clk                 (clk),
        .rst_b               (rst_b),
        .req_dv              (req_dv),
        .dir_req_dv          (dir_req_dv),
        .req_write           (req_write),
        .req_soc             (req_soc),
        .req_addr            (req_addr),
        .req_wdata           (req_wdata),
        .req_user            (req_user),
        .rdata               (rdata),
        .req_hold            (req_hold),
        .mbox_error          (mbox_error),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail)
    );

    mbox_checker checker0 (
        .clk                 (clk),
        .rdata               (rdata),
        .req_hold            (req_hold),
        .mbox_error          (mbox_error),
        .uc_mbox_data_avail  (uc_mbox_data_avail),
        .soc_mbox_data_avail (soc_mbox_data_avail),
        .chk_rdata           (chk_rdata),
        .chk_hold            (chk_hold),
        .chk_err             (chk_err),
        .chk_levels          (chk_levels),
        .exp_value           (exp_value),
        .test_end            (test_end),
        .test_num            (test_num),
        .checks              (checks),
        .errors              (errors)
    );

    // byte address of a register inside the register window
    function automatic mbox_pkg::addr_t csr_addr(input mbox_reg_pkg::reg_off_t off);
        return `MBOX_CSR_BASE | {10'd0, off};
    endfunction

    task automatic add_row(input int kind, input mbox_pkg::addr_t addr, input logic soc,
                           input mbox_pkg::user_t user, input mbox_pkg::data_t wdata,
                           input mbox_pkg::data_t exp);
        row_kind[num_rows]  = kind;
        row_addr[num_rows]  = addr;
        row_soc[num_rows]   = soc;
        row_user[num_rows]  = user;
        row_wdata[num_rows] = wdata;
        row_exp[num_rows]   = exp;
        num_rows++;
    endtask

    task automatic idle_inputs();
        req_dv     = 1'b0;
        dir_req_dv = 1'b0;
        req_write  = 1'b0;
        chk_rdata  = 1'b0;
        chk_hold   = 1'b0;
        chk_err    = 1'b0;
        chk_levels = 1'b0;
        test_end   = 1'b0;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic build_table();
        mbox_pkg::data_t w [11];
        int              k;
        num_rows = 0;
        for (k = 0; k < 11; k++) begin
            w[k] = $urandom();
        end
        // test 1: quiet outputs after reset, then the uc takes the lock
        add_row(K_LEVELS, 16'h0000, 1'b0, 8'h00, 32'd0, 32'd0);
        add_row(K_RD, csr_addr(mbox_reg_pkg::LOCK_OFF), 1'b0, 8'h00, 32'd0, 32'd0);
        add_row(K_RD, csr_addr(mbox_reg_pkg::LOCK_OFF), 1'b0, 8'h00, 32'd0, 32'd1);
        add_row(K_END, 16'h0000, 1'b0, 8'h00, 32'd1, 32'd0);
        // test 2: the uc still owns the lock and fills the mailbox for the SoC
        add_row(K_WR, csr_addr(mbox_reg_pkg::CMD_OFF), 1'b0, 8'h00, 32'h0000_00a5, 32'd0);
        add_row(K_WR, csr_addr(mbox_reg_pkg::DLEN_OFF), 1'b0, 8'h00, 32'd16, 32'd0);
        for (k = 0; k < 4; k++) begin
            add_row(K_WR, csr_addr(mbox_reg_pkg::DATAIN_OFF), 1'b0, 8'h00, w[k], 32'd0);
        end
        add_row(K_RD, csr_addr(mbox_reg_pkg::CMD_OFF), 1'b0, 8'h00, 32'd0, 32'h0000_00a5);
        add_row(K_WR, csr_addr(mbox_reg_pkg::EXECUTE_OFF), 1'b0, 8'h00, 32'd1, 32'd0);
        add_row(K_WAIT, 16'h0000, 1'b1, 8'h00, 32'd0, 32'd0);
        // only the SoC side is told that data is waiting
        add_row(K_LEVELS, 16'h0000, 1'b0, 8'h00, 32'd0, 32'h0000_0001);
        // the next word needs 3 cycles after a dataout read to show up
        for (k = 0; k < 4; k++) begin
            add_row(K_IDLE, 16'h0000, 1'b1, 8'h11, 32'd3, 32'd0);
            add_row(K_RD, csr_addr(mbox_reg_pkg::DATAOUT_OFF), 1'b1, 8'h11, 32'd0, w[k]);
        end
        add_row(K_WR, csr_addr(mbox_reg_pkg::EXECUTE_OFF), 1'b0, 8'h00, 32'd0, 32'd0);
        add_row(K_LEVELS, 16'h0000, 1'b0, 8'h00, 32'd0, 32'd0);
        // the free lock reads 0, and this read hands it to the SoC with user 0x11
        add_row(K_RD, csr_addr(mbox_reg_pkg::LOCK_OFF), 1'b1, 8'h11, 32'd0, 32'd0);
        add_row(K_END, 16'h0000, 1'b0, 8'h00, 32'd2, 32'd0);
        // test 3: writes from user 0x22 are dropped, the uc only sees the 0x11 words
        add_row(K_WR, csr_addr(mbox_reg_pkg::CMD_OFF), 1'b1, 8'h11, 32'h0000_005a, 32'd0);
        add_row(K_WR, csr_addr(mbox_reg_pkg::DLEN_OFF), 1'b1, 8'h11, 32'd12, 32'd0);
        for (k = 0; k < 3; k++) begin
            add_row(K_WR, csr_addr(mbox_reg_pkg::DATAIN_OFF), 1'b1, 8'h11, w[4 + k], 32'd0);
            if (k < 2) begin
                add_row(K_WR, csr_addr(mbox_reg_pkg::DATAIN_OFF), 1'b1, 8'h22, w[7 + k],
                        32'd0);
            end
        end
        add_row(K_WR, csr_addr(mbox_reg_pkg::EXECUTE_OFF), 1'b1, 8'h22, 32'd1, 32'd0);
        add_row(K_LEVELS, 16'h0000, 1'b0, 8'h00, 32'd0, 32'd0);
        add_row(K_WR, csr_addr(mbox_reg_pkg::EXECUTE_OFF), 1'b1, 8'h11, 32'd1, 32'd0);
        add_row(K_WAIT, 16'h0000, 1'b0, 8'h00, 32'd0, 32'd0);
        // now only the uc side is told that data is waiting
        add_row(K_LEVELS, 16'h0000, 1'b0, 8'h00, 32'd0, 32'h0000_0002);
        for (k = 0; k < 3; k++) begin
            add_row(K_IDLE, 16'h0000, 1'b0, 8'h00, 32'd3, 32'd0);
            add_row(K_RD, csr_addr(mbox_reg_pkg::DATAOUT_OFF), 1'b0, 8'h00, 32'd0, w[4 + k]);
        end
        add_row(K_WR, csr_addr(mbox_reg_pkg::EXECUTE_OFF), 1'b1, 8'h11, 32'd0, 32'd0);
        add_row(K_LEVELS, 16'h0000, 1'b0, 8'h00, 32'd0, 32'd0);
        add_row(K_END, 16'h0000, 1'b0, 8'h00, 32'd3, 32'd0);
        // test 4: direct SRAM access by the uc, words 0x10 and 0x11
        add_row(K_DWR, 16'h0040, 1'b0, 8'h00, w[9], 32'd0);
        add_row(K_DWR, 16'h0044, 1'b0, 8'h00, w[10], 32'd0);
        add_row(K_DRD, 16'h0040, 1'b0, 8'h00, 32'd0, w[9]);
        add_row(K_DRD, 16'h0044, 1'b0, 8'h00, 32'd0, w[10]);
        add_row(K_END, 16'h0000, 1'b0, 8'h00, 32'd4, 32'd0);
        // test 5: 0x1C is not a register
        add_row(K_ERR, csr_addr(6'h1c), 1'b0, 8'h00, 32'd0, 32'd1);
        add_row(K_END, 16'h0000, 1'b0, 8'h00, 32'd5, 32'd0);
    endtask

    task automatic apply_row(input int i);
        int   n;
        logic seen;
        @(negedge clk);
        idle_inputs();
        req_addr  = row_addr[i];
        req_soc   = row_soc[i];
        req_user  = row_user[i];
        req_wdata = row_wdata[i];
        exp_value = row_exp[i];
        n         = 0;
        case (row_kind[i])
            K_RD: begin
                req_dv    = 1'b1;
                chk_rdata = 1'b1;
            end
            K_WR: begin
                req_dv    = 1'b1;
                req_write = 1'b1;
            end
            K_ERR: begin
                req_dv  = 1'b1;
                chk_err = 1'b1;
            end
            K_DWR: begin
                // a direct write finishes in its strobe cycle, hold stays low
                dir_req_dv = 1'b1;
                req_write  = 1'b1;
                chk_hold   = 1'b1;
            end
            K_DRD: begin
                dir_req_dv = 1'b1;
                chk_hold   = 1'b1;
                exp_value  = 32'd1;
                @(posedge clk);
                seen = req_hold;
                // the request stays up while hold is high, data comes in the cycle after
                while (seen && n < TIMEOUT) begin
                    @(negedge clk);
                    chk_hold  = 1'b0;
                    chk_rdata = 1'b1;
                    exp_value = row_exp[i];
                    @(posedge clk);
                    seen = req_hold;
                    n++;
                end
                if (seen) begin
                    report_timeout("req_hold to drop");
                end
            end
            K_IDLE: begin
                repeat (row_wdata[i] - 32'd1) @(negedge clk);
            end
            K_LEVELS: begin
                chk_levels = 1'b1;
            end
            K_WAIT: begin
                // row_soc selects which side's level to wait for
                seen = row_soc[i] ? soc_mbox_data_avail : uc_mbox_data_avail;
                while (!seen && n < TIMEOUT) begin
                    @(negedge clk);
                    seen = row_soc[i] ? soc_mbox_data_avail : uc_mbox_data_avail;
                    n++;
                end
                if (!seen) begin
                    report_timeout(row_soc[i] ? "soc_mbox_data_avail" : "uc_mbox_data_avail");
                end
            end
            K_END: begin
                test_end = 1'b1;
                test_num = row_wdata[i];
            end
            default: begin
                idle_inputs();
            end
        endcase
    endtask

    initial begin
        int i;
        void'($urandom(32'h769f_7075));
        rst_b     = 1'b0;
        req_soc   = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_user  = '0;
        exp_value = '0;
        test_num  = 0;
        timed_out = 1'b0;
        idle_inputs();
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;
        for (i = 0; i < num_rows && !timed_out; i++) begin
            apply_row(i);
        end
        @(negedge clk);
        idle_inputs();
        $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
